// File: src/isa_pkg.sv
/*
 * RV32I architectural types shared by the decode stage and its testbench
 * Register index and data word types, opcode classes and instruction field positions
 */

package isa_pkg;

    ////////////////////////////////
    // Widths and basic types
    ////////////////////////////////

    localparam int REG_IDX_W = 5;
    localparam int DATA_W    = 32;
    localparam int OPCODE_W  = 7;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [DATA_W-1:0]    data_t;

    // Register file shape
    localparam int       NUM_REGS   = 32;
    localparam int       READ_PORTS = 2;
    localparam reg_idx_t ZERO_REG   = '0;

    // Low bit of each fixed instruction field
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;

    ////////////////////////////////
    // Opcodes
    ////////////////////////////////

    // Decoded class carried down the pipe
    typedef enum logic [3:0] {
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BRANCH,
        OP_LOAD,
        OP_STORE,
        OP_IMM,
        OP_REG,
        OP_ILLEGAL
    } opcode_e;

    // Raw major opcodes, inst[6:0]
    localparam logic [OPCODE_W-1:0] RV_LUI    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] RV_AUIPC  = 7'b0010111;
    localparam logic [OPCODE_W-1:0] RV_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] RV_JALR   = 7'b1100111;
    localparam logic [OPCODE_W-1:0] RV_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] RV_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] RV_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] RV_OP_IMM = 7'b0010011;
    localparam logic [OPCODE_W-1:0] RV_OP     = 7'b0110011;

endpackage

// File: src/pipe_pkg.sv
/*
 * Pipeline packets around the decode stage
 * Fetch-to-decode input, write-back input and decode-to-execute output
 */

package pipe_pkg;

    // From fetch
    typedef struct packed {
        logic          valid;
        isa_pkg::data_t pc;
        isa_pkg::data_t inst;
    } if_id_packet_t;

    // Result coming back from the end of the pipe
    typedef struct packed {
        logic             valid;
        isa_pkg::reg_idx_t dest;
        isa_pkg::data_t    data;
    } wb_packet_t;

    // To execute
    typedef struct packed {
        logic              valid;
        isa_pkg::data_t     pc;
        isa_pkg::opcode_e   opcode;
        isa_pkg::data_t     rs1_value;
        isa_pkg::data_t     rs2_value;
        isa_pkg::data_t     imm;
        // Zero here means nothing is written back
        isa_pkg::reg_idx_t  dest;
        logic              illegal;
    } id_ex_packet_t;

endpackage

// File: src/mem_dp.sv
/*
 * Register storage with several combinational read ports and one write port
 * A read of the word being written in the same cycle returns the new data
 */

`timescale 1ns/1ps

module mem_dp (
    input  logic                          clock,
    input  logic [isa_pkg::READ_PORTS-1:0] re,
    input  isa_pkg::reg_idx_t              raddr [isa_pkg::READ_PORTS],
    output isa_pkg::data_t                 rdata [isa_pkg::READ_PORTS],
    input  logic                          we,
    input  isa_pkg::reg_idx_t              waddr,
    input  isa_pkg::data_t                 wdata
);

    ////////////////////////////////
    // Storage
    ////////////////////////////////

    // Contents are undefined until written
    isa_pkg::data_t mem [isa_pkg::NUM_REGS];

    // One write per cycle
    always_ff @(posedge clock) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    ////////////////////////////////
    // Read ports
    ////////////////////////////////

    always_comb begin
        for (int p = 0; p < isa_pkg::READ_PORTS; p++) begin
            if (!re[p]) begin
                // Idle port drives zero
                rdata[p] = '0;
            end else if (we && (waddr == raddr[p])) begin
                // Forward the word being written this cycle
                rdata[p] = wdata;
            end else begin
                rdata[p] = mem[raddr[p]];
            end
        end
    end

    ////////////////////////////////
    // Checks
    ////////////////////////////////

    // An unknown write address would corrupt an arbitrary entry
    a_waddr_known: assert property (
        @(posedge clock) we |-> !$isunknown(waddr)
    ) else $error("mem_dp write address has unknown bits");

endmodule

// File: src/regfile.sv
/*
 * Two-read, one-write RV32I register file on top of mem_dp
 * x0 reads as zero and never takes a write
 */

`timescale 1ns/1ps

module regfile (
    input  logic                 clock,
    input  isa_pkg::reg_idx_t     read_idx_1,
    input  isa_pkg::reg_idx_t     read_idx_2,
    input  pipe_pkg::wb_packet_t  wb,
    output isa_pkg::data_t        read_out_1,
    output isa_pkg::data_t        read_out_2
);

    // Memory port signals
    isa_pkg::data_t                 rdata [isa_pkg::READ_PORTS];
    isa_pkg::reg_idx_t              raddr [isa_pkg::READ_PORTS];
    logic [isa_pkg::READ_PORTS-1:0] re;
    logic                           we;

    // Port 0 serves rs1, port 1 serves rs2
    assign raddr[0] = read_idx_1;
    assign raddr[1] = read_idx_2;

    // No access to storage for x0
    assign re[0] = (read_idx_1 != isa_pkg::ZERO_REG);
    assign re[1] = (read_idx_2 != isa_pkg::ZERO_REG);

    // Write only valid results to a real register
    assign we = wb.valid && (wb.dest != isa_pkg::ZERO_REG);

    mem_dp regfile_mem (
        .clock(clock),
        .re   (re),
        .raddr(raddr),
        .rdata(rdata),
        .we   (we),
        .waddr(wb.dest),
        .wdata(wb.data)
    );

    // x0 reads come back zero from the idle memory port
    assign read_out_1 = rdata[0];
    assign read_out_2 = rdata[1];

    ////////////////////////////////
    // Checks
    ////////////////////////////////

    // x0 stays zero even with a write to x0 on the same edge
    a_x0_port1: assert property (
        @(posedge clock) (read_idx_1 == isa_pkg::ZERO_REG) |-> (read_out_1 == '0)
    ) else $error("regfile port 1 read of x0 is not zero");

    a_x0_port2: assert property (
        @(posedge clock) (read_idx_2 == isa_pkg::ZERO_REG) |-> (read_out_2 == '0)
    ) else $error("regfile port 2 read of x0 is not zero");

endmodule

// File: src/decoder.sv
/*
 * Combinational RV32I decoder
 * Gives opcode class, gated register indices, sign-extended immediate and illegal flag
 */

`timescale 1ns/1ps

module decoder (
    input  isa_pkg::data_t    inst,
    output isa_pkg::opcode_e  opcode,
    output isa_pkg::reg_idx_t rs1_idx,
    output isa_pkg::reg_idx_t rs2_idx,
    output isa_pkg::reg_idx_t dest,
    output isa_pkg::data_t    imm,
    output logic             illegal
);

    // Fixed instruction fields
    logic [isa_pkg::OPCODE_W-1:0] major;
    isa_pkg::reg_idx_t            rd_f;
    isa_pkg::reg_idx_t            rs1_f;
    isa_pkg::reg_idx_t            rs2_f;

    assign major = inst[isa_pkg::OPCODE_LSB +: isa_pkg::OPCODE_W];
    assign rd_f  = inst[isa_pkg::RD_LSB  +: isa_pkg::REG_IDX_W];
    assign rs1_f = inst[isa_pkg::RS1_LSB +: isa_pkg::REG_IDX_W];
    assign rs2_f = inst[isa_pkg::RS2_LSB +: isa_pkg::REG_IDX_W];

    ////////////////////////////////
    // Class, indices, immediate
    ////////////////////////////////

    always_comb begin
        // Default is illegal with everything zeroed
        opcode  = isa_pkg::OP_ILLEGAL;
        rs1_idx = isa_pkg::ZERO_REG;
        rs2_idx = isa_pkg::ZERO_REG;
        dest    = isa_pkg::ZERO_REG;
        imm     = '0;

        case (major)
            isa_pkg::RV_LUI: begin
                opcode = isa_pkg::OP_LUI;
                dest   = rd_f;
                imm    = {inst[31:12], 12'b0};
            end
            isa_pkg::RV_AUIPC: begin
                opcode = isa_pkg::OP_AUIPC;
                dest   = rd_f;
                imm    = {inst[31:12], 12'b0};
            end
            isa_pkg::RV_JAL: begin
                opcode = isa_pkg::OP_JAL;
                dest   = rd_f;
                // J format, scrambled 20-bit offset
                imm    = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                          inst[30:21], 1'b0};
            end
            isa_pkg::RV_JALR: begin
                opcode  = isa_pkg::OP_JALR;
                rs1_idx = rs1_f;
                dest    = rd_f;
                imm     = {{20{inst[31]}}, inst[31:20]};
            end
            isa_pkg::RV_BRANCH: begin
                // B format, no destination
                opcode  = isa_pkg::OP_BRANCH;
                rs1_idx = rs1_f;
                rs2_idx = rs2_f;
                imm     = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                           inst[11:8], 1'b0};
            end
            isa_pkg::RV_LOAD: begin
                opcode  = isa_pkg::OP_LOAD;
                rs1_idx = rs1_f;
                dest    = rd_f;
                imm     = {{20{inst[31]}}, inst[31:20]};
            end
            isa_pkg::RV_STORE: begin
                // S format, offset split around rd field
                opcode  = isa_pkg::OP_STORE;
                rs1_idx = rs1_f;
                rs2_idx = rs2_f;
                imm     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            isa_pkg::RV_OP_IMM: begin
                opcode  = isa_pkg::OP_IMM;
                rs1_idx = rs1_f;
                dest    = rd_f;
                imm     = {{20{inst[31]}}, inst[31:20]};
            end
            isa_pkg::RV_OP: begin
                // R format has no immediate
                opcode  = isa_pkg::OP_REG;
                rs1_idx = rs1_f;
                rs2_idx = rs2_f;
                dest    = rd_f;
            end
            default: begin
                opcode = isa_pkg::OP_ILLEGAL;
            end
        endcase
    end

    assign illegal = (opcode == isa_pkg::OP_ILLEGAL);

endmodule

// File: src/id_stage.sv
/*
 * Decode stage top: decoder plus register file, one register on the output
 * Takes a fetch packet and a write-back packet each cycle, no back-pressure
 */

`timescale 1ns/1ps

module id_stage (
    input  logic                    clock,
    input  logic                    rst,
    input  pipe_pkg::if_id_packet_t  if_id,
    input  pipe_pkg::wb_packet_t     wb,
    output pipe_pkg::id_ex_packet_t  id_ex
);

    // Decoder results
    isa_pkg::opcode_e  dec_opcode;
    isa_pkg::reg_idx_t dec_rs1_idx;
    isa_pkg::reg_idx_t dec_rs2_idx;
    isa_pkg::reg_idx_t dec_dest;
    isa_pkg::data_t    dec_imm;
    logic             dec_illegal;

    // Operands, already forwarded from write-back
    isa_pkg::data_t    rs1_value;
    isa_pkg::data_t    rs2_value;

    pipe_pkg::id_ex_packet_t id_next;

    ////////////////////////////////
    // Decode and operand read
    ////////////////////////////////

    decoder u_decoder (
        .inst   (if_id.inst),
        .opcode (dec_opcode),
        .rs1_idx(dec_rs1_idx),
        .rs2_idx(dec_rs2_idx),
        .dest   (dec_dest),
        .imm    (dec_imm),
        .illegal(dec_illegal)
    );

    // Unused sources arrive as x0 and come back zero
    regfile u_regfile (
        .clock     (clock),
        .read_idx_1(dec_rs1_idx),
        .read_idx_2(dec_rs2_idx),
        .wb        (wb),
        .read_out_1(rs1_value),
        .read_out_2(rs2_value)
    );

    ////////////////////////////////
    // Output packet
    ////////////////////////////////

    always_comb begin
        id_next.valid     = if_id.valid;
        id_next.pc        = if_id.pc;
        id_next.opcode    = dec_opcode;
        id_next.rs1_value = rs1_value;
        id_next.rs2_value = rs2_value;
        id_next.imm       = dec_imm;
        id_next.dest      = dec_dest;
        id_next.illegal   = dec_illegal;
    end

    // One cycle from input packet to output packet
    always_ff @(posedge clock) begin
        if (rst) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex <= id_next;
        end
    end

    ////////////////////////////////
    // Checks
    ////////////////////////////////

    // An illegal instruction must never reach write-back with a target
    a_illegal_no_dest: assert property (
        @(posedge clock) disable iff (rst)
        (id_ex.valid && id_ex.illegal) |-> (id_ex.dest == isa_pkg::ZERO_REG)
    ) else $error("id_stage illegal packet carries a destination");

endmodule

// File: verif/id_stage_tb.sv
/*
 * Random-stimulus testbench for the decode stage
 * Keeps a reference register file and decode model and checks every output packet
 */

`timescale 1ns/1ps

module id_stage_tb;

    localparam int WATCHDOG_CYCLES = 10000;
    localparam int STREAM_CYCLES   = 2000;

    logic                    clock;
    logic                    rst;
    pipe_pkg::if_id_packet_t if_id;
    pipe_pkg::wb_packet_t    wb;
    pipe_pkg::id_ex_packet_t id_ex;

    // Reference register contents
    isa_pkg::data_t          model_regs [isa_pkg::NUM_REGS];

    // Prediction for the packet that leaves the DUT one edge later
    pipe_pkg::id_ex_packet_t pending;
    logic                    pending_active;
    string                   pending_name;

    isa_pkg::data_t          pc_next;
    int                      seed;
    int                      error_count;

    id_stage DUT (
        .clock(clock),
        .rst  (rst),
        .if_id(if_id),
        .wb   (wb),
        .id_ex(id_ex)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////

    function automatic isa_pkg::data_t rand_word();
        return $random(seed);
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic isa_pkg::reg_idx_t rand_idx();
        return isa_pkg::reg_idx_t'(rand_below(isa_pkg::NUM_REGS));
    endfunction

    function automatic isa_pkg::reg_idx_t rand_nonzero_idx();
        return isa_pkg::reg_idx_t'(1 + rand_below(isa_pkg::NUM_REGS - 1));
    endfunction

    // R-type with random funct bits, reads both sources
    function automatic isa_pkg::data_t make_op(input isa_pkg::reg_idx_t rs1,
                                               input isa_pkg::reg_idx_t rs2,
                                               input isa_pkg::reg_idx_t rd);
        isa_pkg::data_t w;
        w        = rand_word();
        w[6:0]   = isa_pkg::RV_OP;
        w[11:7]  = rd;
        w[19:15] = rs1;
        w[24:20] = rs2;
        return w;
    endfunction

    function automatic logic major_listed(input logic [6:0] m);
        return m inside {isa_pkg::RV_LUI, isa_pkg::RV_AUIPC, isa_pkg::RV_JAL,
                         isa_pkg::RV_JALR, isa_pkg::RV_BRANCH, isa_pkg::RV_LOAD,
                         isa_pkg::RV_STORE, isa_pkg::RV_OP_IMM, isa_pkg::RV_OP};
    endfunction

    // Any major opcode, one pick in ten is illegal
    function automatic isa_pkg::data_t random_inst();
        isa_pkg::data_t w;
        w = rand_word();
        case (rand_below(10))
            0: w[6:0] = isa_pkg::RV_LUI;
            1: w[6:0] = isa_pkg::RV_AUIPC;
            2: w[6:0] = isa_pkg::RV_JAL;
            3: w[6:0] = isa_pkg::RV_JALR;
            4: w[6:0] = isa_pkg::RV_BRANCH;
            5: w[6:0] = isa_pkg::RV_LOAD;
            6: w[6:0] = isa_pkg::RV_STORE;
            7: w[6:0] = isa_pkg::RV_OP_IMM;
            8: w[6:0] = isa_pkg::RV_OP;
            default: begin
                // Listed opcodes all end in 2'b11, so clearing bit 0 leaves the set
                if (major_listed(w[6:0])) begin
                    w[0] = 1'b0;
                end
            end
        endcase
        return w;
    endfunction

    function automatic pipe_pkg::if_id_packet_t valid_fetch(input isa_pkg::data_t inst);
        pipe_pkg::if_id_packet_t p;
        p.valid = 1'b1;
        p.pc    = pc_next;
        p.inst  = inst;
        pc_next = pc_next + 32'd4;
        return p;
    endfunction

    // Bubble with random payload
    function automatic pipe_pkg::if_id_packet_t idle_fetch();
        pipe_pkg::if_id_packet_t p;
        p.valid = 1'b0;
        p.pc    = rand_word();
        p.inst  = rand_word();
        return p;
    endfunction

    function automatic pipe_pkg::wb_packet_t make_wb(input logic valid,
                                                     input isa_pkg::reg_idx_t dest,
                                                     input isa_pkg::data_t data);
        pipe_pkg::wb_packet_t w;
        w.valid = valid;
        w.dest  = dest;
        w.data  = data;
        return w;
    endfunction

    ////////////////////////////////
    // Reference model
    ////////////////////////////////

    function automatic isa_pkg::data_t imm_i(input isa_pkg::data_t inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic isa_pkg::data_t imm_s(input isa_pkg::data_t inst);
        return {{20{inst[31]}}, inst[31:25], inst[11:7]};
    endfunction

    function automatic isa_pkg::data_t imm_b(input isa_pkg::data_t inst);
        logic [12:0] v;
        v       = '0;
        v[12]   = inst[31];
        v[11]   = inst[7];
        v[10:5] = inst[30:25];
        v[4:1]  = inst[11:8];
        return {{19{v[12]}}, v};
    endfunction

    function automatic isa_pkg::data_t imm_u(input isa_pkg::data_t inst);
        return {inst[31:12], 12'h000};
    endfunction

    function automatic isa_pkg::data_t imm_j(input isa_pkg::data_t inst);
        logic [20:0] v;
        v        = '0;
        v[20]    = inst[31];
        v[19:12] = inst[19:12];
        v[11]    = inst[20];
        v[10:1]  = inst[30:21];
        return {{11{v[20]}}, v};
    endfunction

    // x0 is zero, a same-cycle write wins over the stored word
    function automatic isa_pkg::data_t read_model_reg(input isa_pkg::reg_idx_t idx,
                                                      input pipe_pkg::wb_packet_t w);
        if (idx == isa_pkg::ZERO_REG) begin
            return '0;
        end
        if (w.valid && (w.dest == idx)) begin
            return w.data;
        end
        return model_regs[idx];
    endfunction

    function automatic pipe_pkg::id_ex_packet_t predict_packet(
        input pipe_pkg::if_id_packet_t p,
        input pipe_pkg::wb_packet_t    w
    );
        pipe_pkg::id_ex_packet_t e;
        logic                    use1;
        logic                    use2;
        logic                    has_rd;
        isa_pkg::reg_idx_t       s1;
        isa_pkg::reg_idx_t       s2;
        e       = '0;
        e.valid = p.valid;
        e.pc    = p.pc;
        use1    = 1'b1;
        use2    = 1'b0;
        has_rd  = 1'b1;
        case (p.inst[6:0])
            isa_pkg::RV_LUI: begin
                e.opcode = isa_pkg::OP_LUI;
                e.imm    = imm_u(p.inst);
                use1     = 1'b0;
            end
            isa_pkg::RV_AUIPC: begin
                e.opcode = isa_pkg::OP_AUIPC;
                e.imm    = imm_u(p.inst);
                use1     = 1'b0;
            end
            isa_pkg::RV_JAL: begin
                e.opcode = isa_pkg::OP_JAL;
                e.imm    = imm_j(p.inst);
                use1     = 1'b0;
            end
            isa_pkg::RV_JALR: begin
                e.opcode = isa_pkg::OP_JALR;
                e.imm    = imm_i(p.inst);
            end
            isa_pkg::RV_BRANCH: begin
                e.opcode = isa_pkg::OP_BRANCH;
                e.imm    = imm_b(p.inst);
                use2     = 1'b1;
                has_rd   = 1'b0;
            end
            isa_pkg::RV_LOAD: begin
                e.opcode = isa_pkg::OP_LOAD;
                e.imm    = imm_i(p.inst);
            end
            isa_pkg::RV_STORE: begin
                e.opcode = isa_pkg::OP_STORE;
                e.imm    = imm_s(p.inst);
                use2     = 1'b1;
                has_rd   = 1'b0;
            end
            isa_pkg::RV_OP_IMM: begin
                e.opcode = isa_pkg::OP_IMM;
                e.imm    = imm_i(p.inst);
            end
            isa_pkg::RV_OP: begin
                e.opcode = isa_pkg::OP_REG;
                use2     = 1'b1;
            end
            default: begin
                e.opcode  = isa_pkg::OP_ILLEGAL;
                e.illegal = 1'b1;
                use1      = 1'b0;
                has_rd    = 1'b0;
            end
        endcase
        // Unused sources read x0
        s1          = use1 ? p.inst[19:15] : isa_pkg::ZERO_REG;
        s2          = use2 ? p.inst[24:20] : isa_pkg::ZERO_REG;
        e.dest      = has_rd ? p.inst[11:7] : isa_pkg::ZERO_REG;
        e.rs1_value = read_model_reg(s1, w);
        e.rs2_value = read_model_reg(s2, w);
        return e;
    endfunction

    ////////////////////////////////
    // Compare tasks
    ////////////////////////////////

    task automatic check_data(input string name, input isa_pkg::data_t exp,
                              input isa_pkg::data_t act);
        if (act !== exp) begin
            error_count++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_idx(input string name, input isa_pkg::reg_idx_t exp,
                             input isa_pkg::reg_idx_t act);
        if (act !== exp) begin
            error_count++;
            $display("Error %s: expected x%0d, actual x%0d", name, exp, act);
        end
    endtask

    task automatic check_opcode(input string name, input isa_pkg::opcode_e exp,
                                input isa_pkg::opcode_e act);
        if (act !== exp) begin
            error_count++;
            $display("Error %s: expected %s (%0d), actual %s (%0d)",
                     name, exp.name(), exp, act.name(), act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_packet(input string name, input pipe_pkg::id_ex_packet_t exp,
                                input pipe_pkg::id_ex_packet_t act);
        check_bit({name, " valid"}, exp.valid, act.valid);
        // Payload is don't-care on a bubble
        if (exp.valid) begin
            check_data({name, " pc"}, exp.pc, act.pc);
            check_opcode({name, " opcode"}, exp.opcode, act.opcode);
            check_data({name, " rs1_value"}, exp.rs1_value, act.rs1_value);
            check_data({name, " rs2_value"}, exp.rs2_value, act.rs2_value);
            check_data({name, " imm"}, exp.imm, act.imm);
            check_idx({name, " dest"}, exp.dest, act.dest);
            check_bit({name, " illegal"}, exp.illegal, act.illegal);
        end
    endtask

    ////////////////////////////////
    // Cycle driver
    ////////////////////////////////

    // Drive one cycle, check the packet from the cycle before
    task automatic drive_and_check(input string name, input pipe_pkg::if_id_packet_t p,
                                   input pipe_pkg::wb_packet_t w);
        pipe_pkg::id_ex_packet_t expected;
        @(posedge clock);
        if_id <= p;
        wb    <= w;
        expected = predict_packet(p, w);
        // Write lands on the edge that captures this packet
        if (w.valid && (w.dest != isa_pkg::ZERO_REG)) begin
            model_regs[w.dest] = w.data;
        end
        @(negedge clock);
        if (pending_active) begin
            check_packet(pending_name, pending, id_ex);
        end
        pending        = expected;
        pending_name   = name;
        pending_active = 1'b1;
    endtask

    task automatic wait_output_idle(input int max_cycles);
        int n;
        n = 0;
        while ((id_ex.valid !== 1'b0) && (n < max_cycles)) begin
            @(negedge clock);
            n++;
        end
        if (id_ex.valid !== 1'b0) begin
            error_count++;
            $display("Output valid did not clear within %0d cycles of reset", max_cycles);
        end
    endtask

    ////////////////////////////////
    // Test sequence
    ////////////////////////////////

    initial begin
        pipe_pkg::wb_packet_t no_wb;
        isa_pkg::reg_idx_t    r;
        seed           = 76855;
        error_count    = 0;
        pending        = '0;
        pending_active = 1'b0;
        pending_name   = "";
        pc_next        = 32'h0000_1000;
        no_wb          = '0;
        rst            = 1'b1;
        if_id          = '0;
        wb             = '0;

        // Valid fetches during reset must not come out
        for (int i = 0; i < 10; i++) begin
            @(posedge clock);
            if (i == 9) begin
                rst   <= 1'b0;
                if_id <= idle_fetch();
            end else begin
                if_id <= valid_fetch(rand_word());
            end
            @(negedge clock);
            check_bit("reset", 1'b0, id_ex.valid);
        end
        wait_output_idle(4);
        // Bubble driven with the reset release comes out first
        pending        = '0;
        pending_name   = "after_reset";
        pending_active = 1'b1;
        drive_and_check("invalid_in", idle_fetch(), no_wb);

        // Fill x1..x31 before any operand is checked
        for (int i = 1; i < isa_pkg::NUM_REGS; i++) begin
            drive_and_check("write_all", idle_fetch(),
                            make_wb(1'b1, isa_pkg::reg_idx_t'(i), rand_word()));
        end
        for (int i = 0; i < 40; i++) begin
            drive_and_check("read_regs", valid_fetch(make_op(rand_idx(), rand_idx(),
                            rand_idx())), no_wb);
        end

        // x0 ignores writes
        for (int i = 0; i < 10; i++) begin
            drive_and_check("x0_write", valid_fetch(make_op(isa_pkg::ZERO_REG,
                            isa_pkg::ZERO_REG, rand_idx())),
                            make_wb(1'b1, isa_pkg::ZERO_REG, rand_word()));
            drive_and_check("x0_read", valid_fetch(make_op(isa_pkg::ZERO_REG,
                            rand_idx(), rand_idx())), no_wb);
        end

        // Same-cycle write and read, on each port
        for (int i = 0; i < 30; i++) begin
            r = rand_nonzero_idx();
            drive_and_check("bypass_rs1", valid_fetch(make_op(r, rand_idx(), rand_idx())),
                            make_wb(1'b1, r, rand_word()));
            r = rand_nonzero_idx();
            drive_and_check("bypass_rs2", valid_fetch(make_op(rand_idx(), r, rand_idx())),
                            make_wb(1'b1, r, rand_word()));
        end

        for (int i = 0; i < 300; i++) begin
            drive_and_check("decode", valid_fetch(random_inst()), no_wb);
        end

        // Back-to-back packets with random write-backs, some to x0
        for (int i = 0; i < STREAM_CYCLES; i++) begin
            drive_and_check("stream", valid_fetch(random_inst()),
                            make_wb(rand_below(2) == 1, rand_idx(), rand_word()));
        end
        drive_and_check("flush", idle_fetch(), no_wb);

        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Bound on the whole run
    initial begin
        for (int n = 0; n < WATCHDOG_CYCLES; n++) begin
            @(posedge clock);
        end
        $display("Timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: sim.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/mem_dp.sv
src/regfile.sv
src/decoder.sv
src/id_stage.sv
verif/id_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_MSG="Simulation completed successfully"

verilator --binary --timing --assert --top-module id_stage_tb \
    -f sim.f -Mdir obj_dir -o id_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/id_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "$PASS_MSG" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
